// ==== bench/axi_sram_assert.sv ====
module axi_sram_assert #(
  parameter int DATA_WIDTH = 16
) (
  input logic                  axi_clk,
  input logic                  axi_resetn,
  input logic                  awready,
  input logic                  arready,
  input logic                  bvalid,
  input logic                  bready,
  input logic                  rvalid,
  input logic                  rready,
  input logic [DATA_WIDTH-1:0] rdata,
  input logic                  sram_we_n,
  input logic                  sram_oe_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // a pending response stays up and unchanged
  a_bvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  // no new address while a response is pending
  a_no_addr: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    (bvalid || rvalid) |-> !awready && !arready)
    else $error("address accepted while a response was pending");

  a_we_oe: assert property (@(posedge axi_clk) disable iff (!axi_resetn)
    !(!sram_we_n && !sram_oe_n))
    else $error("sram_we_n and sram_oe_n low together");

endmodule

bind axi_sram_top axi_sram_assert #(.DATA_WIDTH(DATA_WIDTH)) u_axi_sram_assert (.*);

// ==== bench/axi_sram_golden.txt ====
# op addr wdata wstrb expect, all hex; op W write, R read, B write and read offered together
# expect is the read data and is unused for W
R 123 0000 0 0000
W 123 a5c3 3 0000
R 123 0000 0 a5c3
W 7fe 1234 0 0000
R 7fe 0000 0 1234
B 040 beef 3 beef
W 123 0f0f 1 0000
R 123 0000 0 0f0f
B 7fe cafe 0 cafe
R 040 0000 0 beef
R fff 0000 0 0000
R 7fe 0000 0 cafe

// ==== bench/sram_model.sv ====
module sram_model #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  logic [ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [DATA_WIDTH-1:0] sram_data,
  input  logic                  sram_we_n,
  input  logic                  sram_oe_n,
  input  logic                  sram_ce_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // sparse storage, unwritten words read as zero
  logic [DATA_WIDTH-1:0] mem [logic [ADDR_WIDTH-1:0]];
  logic [DATA_WIDTH-1:0] rd_word;

  // word stored on the rising edge of we_n
  always @(posedge sram_we_n) begin
    if (sram_ce_n === 1'b0) begin
      mem[sram_addr] = sram_data;
    end
  end

  always @(sram_addr or sram_oe_n or sram_ce_n) begin
    rd_word = mem.exists(sram_addr) ? mem[sram_addr] : '0;
  end

  assign sram_data = (!sram_ce_n && !sram_oe_n && sram_we_n) ? rd_word : 'z;

endmodule

// ==== bench/tb_axi_sram.sv ====
module tb_axi_sram;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ADDR_WIDTH  = 12;
  localparam int DATA_WIDTH  = 16;
  localparam int WAIT_CYCLES = 2;

  logic                  axi_clk, axi_resetn;
  logic [ADDR_WIDTH-1:0] awaddr, araddr, sram_addr;
  logic [DATA_WIDTH-1:0] wdata, rdata;
  logic [1:0]            wstrb;
  sram_pkg::axi_resp_t   bresp, rresp;
  logic                  awvalid, awready, wvalid, wready, bvalid, bready;
  logic                  arvalid, arready, rvalid, rready;
  logic                  sram_we_n, sram_oe_n, sram_ce_n;
  wire  [DATA_WIDTH-1:0] sram_data;

  // one entry per golden operation
  logic [15:0] op_q[$], addr_q[$], wdata_q[$], strb_q[$], exp_q[$];
  int          err_count, check_count, line_count;
  bit          loaded;

  axi_sram_top #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .WAIT_CYCLES(WAIT_CYCLES)
  ) u_axi_sram_top (.*);

  sram_model #(.ADDR_WIDTH(ADDR_WIDTH), .DATA_WIDTH(DATA_WIDTH)) u_sram_model (.*);

  initial begin
    axi_clk = 1'b0;
    forever #5 axi_clk = ~axi_clk;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      err_count++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic offer_write(input logic [15:0] addr, input logic [15:0] data,
                             input logic [15:0] strb);
    awaddr  = addr[ADDR_WIDTH-1:0];
    wdata   = data;
    wstrb   = strb[1:0];
    awvalid = 1'b1;
    wvalid  = 1'b1;
  endtask

  task automatic offer_read(input logic [15:0] addr);
    araddr  = addr[ADDR_WIDTH-1:0];
    arvalid = 1'b1;
  endtask

  task automatic finish_write(input string name);
    int delay;
    do @(negedge axi_clk); while (!awready);
    // a read offered alongside has to wait
    check_value({name, " arready"}, 0, arready);
    check_value({name, " wready"}, 1, wready);
    // the write stays offered, so a second accept would show up here
    do @(negedge axi_clk); while (!bvalid);
    // okay is response code zero
    check_value({name, " bresp"}, 2'b00, bresp);
    check_value({name, " no address"}, 0, arready | awready);
    delay = $urandom % 4;
    repeat (delay) begin
      @(negedge axi_clk);
      check_value({name, " no address"}, 0, arready | awready);
    end
    @(posedge axi_clk);
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    bready  = 1'b1;
    @(posedge axi_clk);
    #1;
    bready = 1'b0;
  endtask

  task automatic finish_read(input string name, input logic [15:0] expected);
    int delay;
    do @(negedge axi_clk); while (!arready);
    // the read stays offered until rready
    do @(negedge axi_clk); while (!rvalid);
    check_value({name, " rresp"}, 2'b00, rresp);
    check_value({name, " rdata"}, expected, rdata);
    check_value({name, " no address"}, 0, arready | awready);
    delay = $urandom % 4;
    // master stalls, data must hold and no address goes in
    repeat (delay) begin
      @(negedge axi_clk);
      check_value({name, " rdata held"}, expected, rdata);
      check_value({name, " no address"}, 0, arready | awready);
    end
    @(posedge axi_clk);
    #1;
    arvalid = 1'b0;
    rready  = 1'b1;
    @(posedge axi_clk);
    #1;
    rready = 1'b0;
  endtask

  initial begin
    string       line, name;
    int          fd, n;
    logic [7:0]  op;
    logic [15:0] a, d, s, e;
    void'($urandom(32'he45d_0c90));
    axi_resetn = 1'b0;
    awaddr     = '0;
    awvalid    = 1'b0;
    wdata      = '0;
    wstrb      = '0;
    wvalid     = 1'b0;
    bready     = 1'b0;
    araddr     = '0;
    arvalid    = 1'b0;
    rready     = 1'b0;
    fd = $fopen("bench/axi_sram_golden.txt", "r");
    if (fd == 0) begin
      err_count++;
      $display("could not open the golden stimulus file");
    end else begin
      while (!$feof(fd)) begin
        if ($fgets(line, fd) != 0) begin
          line_count++;
          // comment and blank lines carry no operation
          if (line.len() > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%c %h %h %h %h", op, a, d, s, e);
            if (n != 5) begin
              err_count++;
              $display("golden line %0d does not hold five fields", line_count);
            end else begin
              op_q.push_back({8'h00, op});
              addr_q.push_back(a);
              wdata_q.push_back(d);
              strb_q.push_back(s);
              exp_q.push_back(e);
            end
          end
        end
      end
      $fclose(fd);
    end
    loaded = 1'b1;
    repeat (3) @(posedge axi_clk);
    #1;
    axi_resetn = 1'b1;
    @(posedge axi_clk);
    #1;
    foreach (op_q[i]) begin
      name = $sformatf("op %0d %c addr %h", i, op_q[i][7:0], addr_q[i]);
      case (op_q[i][7:0])
        "W": begin
          offer_write(addr_q[i], wdata_q[i], strb_q[i]);
          finish_write(name);
        end
        "R": begin
          offer_read(addr_q[i]);
          finish_read(name, exp_q[i]);
        end
        "B": begin
          offer_write(addr_q[i], wdata_q[i], strb_q[i]);
          offer_read(addr_q[i]);
          finish_write(name);
          finish_read(name, exp_q[i]);
        end
        default: begin
          err_count++;
          $display("unknown operation in golden entry %0d", i);
        end
      endcase
    end
    $display("checks run %0d, errors %0d", check_count, err_count);
    if (err_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // budget scales with the golden file length
  initial begin
    wait (loaded);
    repeat (line_count * (WAIT_CYCLES + 12)) @(posedge axi_clk);
    $display("timed out, transactions still running after %0d cycles",
             line_count * (WAIT_CYCLES + 12));
    $display("TEST FAIL");
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/sram_pkg.sv
verilog/sram_access_seq.sv
verilog/sram_pin_io.sv
verilog/axi_sram_slave.sv
verilog/axi_sram_top.sv
bench/sram_model.sv
bench/axi_sram_assert.sv
bench/tb_axi_sram.sv

// ==== verilog/axi_sram_slave.sv ====
module axi_sram_slave #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  logic                          axi_clk,
  input  logic                          axi_resetn,

  input  logic [ADDR_WIDTH-1:0]         awaddr,
  input  logic                          awvalid,
  output logic                          awready,

  input  logic [DATA_WIDTH-1:0]         wdata,
  input  logic [(DATA_WIDTH+7)/8-1:0]   wstrb,
  input  logic                          wvalid,
  output logic                          wready,

  output sram_pkg::axi_resp_t           bresp,
  output logic                          bvalid,
  input  logic                          bready,

  input  logic [ADDR_WIDTH-1:0]         araddr,
  input  logic                          arvalid,
  output logic                          arready,

  output logic [DATA_WIDTH-1:0]         rdata,
  output sram_pkg::axi_resp_t           rresp,
  output logic                          rvalid,
  input  logic                          rready,

  output logic                          acc_start,
  output logic                          acc_write,
  output logic [ADDR_WIDTH-1:0]         acc_addr,
  output logic [DATA_WIDTH-1:0]         acc_wdata,
  input  logic                          acc_done,
  input  logic [DATA_WIDTH-1:0]         cap_data
);

  sram_pkg::slave_state_t state;
  sram_pkg::slave_state_t state_next;

  logic wr_take;
  logic rd_take;

  // write has priority over a read offered in the same idle cycle
  assign wr_take = (state == sram_pkg::IDLE) && awvalid && wvalid;
  assign rd_take = (state == sram_pkg::IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = wr_take;
  assign wready  = wr_take;
  assign arready = rd_take;

  always_comb begin
    state_next = state;
    case (state)
      sram_pkg::IDLE: begin
        if (wr_take) begin
          state_next = sram_pkg::WRITE_WAIT;
        end else if (rd_take) begin
          state_next = sram_pkg::READ_WAIT;
        end
      end
      sram_pkg::WRITE_WAIT: begin
        if (acc_done) begin
          state_next = sram_pkg::WRITE_RESP;
        end
      end
      sram_pkg::WRITE_RESP: begin
        if (bready) begin
          state_next = sram_pkg::IDLE;
        end
      end
      sram_pkg::READ_WAIT: begin
        if (acc_done) begin
          state_next = sram_pkg::READ_RESP;
        end
      end
      sram_pkg::READ_RESP: begin
        if (rready) begin
          state_next = sram_pkg::IDLE;
        end
      end
      default: begin
        state_next = sram_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state     <= sram_pkg::IDLE;
      acc_start <= 1'b0;
    end else begin
      state     <= state_next;
      // one pulse, the cycle after the address handshake
      acc_start <= wr_take || rd_take;
    end
  end

  // latched request and held read data
  always_ff @(posedge axi_clk) begin
    if (wr_take) begin
      acc_write <= 1'b1;
      acc_addr  <= awaddr;
      acc_wdata <= wdata;
    end else if (rd_take) begin
      acc_write <= 1'b0;
      acc_addr  <= araddr;
    end
    if ((state == sram_pkg::READ_WAIT) && acc_done) begin
      rdata <= cap_data;
    end
  end

  // responses stay up until the master takes them
  assign bvalid = (state == sram_pkg::WRITE_RESP);
  assign rvalid = (state == sram_pkg::READ_RESP);
  assign bresp  = sram_pkg::RESP_OKAY;
  assign rresp  = sram_pkg::RESP_OKAY;

endmodule

// ==== verilog/axi_sram_top.sv ====
module axi_sram_top #(
  parameter int ADDR_WIDTH  = 20,
  parameter int DATA_WIDTH  = 16,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                        axi_clk,
  input  logic                        axi_resetn,

  input  logic [ADDR_WIDTH-1:0]       awaddr,
  input  logic                        awvalid,
  output logic                        awready,
  input  logic [DATA_WIDTH-1:0]       wdata,
  input  logic [(DATA_WIDTH+7)/8-1:0] wstrb,
  input  logic                        wvalid,
  output logic                        wready,
  output sram_pkg::axi_resp_t         bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  logic [ADDR_WIDTH-1:0]       araddr,
  input  logic                        arvalid,
  output logic                        arready,
  output logic [DATA_WIDTH-1:0]       rdata,
  output sram_pkg::axi_resp_t         rresp,
  output logic                        rvalid,
  input  logic                        rready,

  output logic [ADDR_WIDTH-1:0]       sram_addr,
  inout  wire  [DATA_WIDTH-1:0]       sram_data,
  output logic                        sram_we_n,
  output logic                        sram_oe_n,
  output logic                        sram_ce_n
);

  // slave to sequencer
  logic                  acc_start;
  logic                  acc_write;
  logic [ADDR_WIDTH-1:0] acc_addr;
  logic [DATA_WIDTH-1:0] acc_wdata;
  logic                  acc_done;

  // sequencer to pin block
  logic [ADDR_WIDTH-1:0] pin_addr;
  logic [DATA_WIDTH-1:0] pin_wdata;
  logic                  pin_drive;
  logic                  pin_we;
  logic                  pin_oe;
  logic                  pin_ce;
  logic                  cap_en;

  // pin block back to slave
  logic [DATA_WIDTH-1:0] cap_data;

  axi_sram_slave #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_axi_sram_slave (.*);

  sram_access_seq #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH),
    .WAIT_CYCLES(WAIT_CYCLES)
  ) u_sram_access_seq (.*);

  sram_pin_io #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) u_sram_pin_io (.*);

endmodule

// ==== verilog/sram_access_seq.sv ====
module sram_access_seq #(
  parameter int ADDR_WIDTH  = 20,
  parameter int DATA_WIDTH  = 16,
  parameter int WAIT_CYCLES = 2
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,

  input  logic                  acc_start,
  input  logic                  acc_write,
  input  logic [ADDR_WIDTH-1:0] acc_addr,
  input  logic [DATA_WIDTH-1:0] acc_wdata,
  output logic                  acc_done,

  output logic [ADDR_WIDTH-1:0] pin_addr,
  output logic [DATA_WIDTH-1:0] pin_wdata,
  output logic                  pin_drive,
  output logic                  pin_we,
  output logic                  pin_oe,
  output logic                  pin_ce,
  output logic                  cap_en
);

  // at least one bit, even with no wait states
  localparam int CNT_WIDTH = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  typedef logic [CNT_WIDTH-1:0]  wait_cnt_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [DATA_WIDTH-1:0] data_t;

  localparam wait_cnt_t WAIT_LOAD = wait_cnt_t'(WAIT_CYCLES);

  sram_pkg::seq_state_t state;
  wait_cnt_t            wait_cnt;
  logic                 write_q;
  addr_t                addr_q;
  data_t                wdata_q;
  logic                 strobe_last;

  assign strobe_last = (state == sram_pkg::SEQ_ACCESS) && (wait_cnt == '0);

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      state    <= sram_pkg::SEQ_IDLE;
      wait_cnt <= '0;
      acc_done <= 1'b0;
    end else begin
      // done lines up with the last chip strobe cycle plus one
      acc_done <= (state == sram_pkg::SEQ_DONE);
      case (state)
        sram_pkg::SEQ_IDLE: begin
          if (acc_start) begin
            state    <= sram_pkg::SEQ_ACCESS;
            wait_cnt <= WAIT_LOAD;
          end
        end
        sram_pkg::SEQ_ACCESS: begin
          if (wait_cnt == '0) begin
            state <= sram_pkg::SEQ_DONE;
          end else begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        default: begin
          state <= sram_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // address and data held from start until the next access
  always_ff @(posedge axi_clk) begin
    if ((state == sram_pkg::SEQ_IDLE) && acc_start) begin
      write_q <= acc_write;
      addr_q  <= acc_addr;
      wdata_q <= acc_wdata;
    end
  end

  assign pin_addr  = addr_q;
  assign pin_wdata = wdata_q;

  // chip select and bus drive run one cycle past the strobe
  assign pin_ce    = (state != sram_pkg::SEQ_IDLE);
  assign pin_drive = pin_ce && write_q;
  assign pin_we    = (state == sram_pkg::SEQ_ACCESS) && write_q;
  assign pin_oe    = (state == sram_pkg::SEQ_ACCESS) && !write_q;
  assign cap_en    = strobe_last && !write_q;

endmodule

// ==== verilog/sram_pin_io.sv ====
module sram_pin_io #(
  parameter int ADDR_WIDTH = 20,
  parameter int DATA_WIDTH = 16
) (
  input  logic                  axi_clk,
  input  logic                  axi_resetn,

  input  logic [ADDR_WIDTH-1:0] pin_addr,
  input  logic [DATA_WIDTH-1:0] pin_wdata,
  input  logic                  pin_drive,
  input  logic                  pin_we,
  input  logic                  pin_oe,
  input  logic                  pin_ce,
  input  logic                  cap_en,
  output logic [DATA_WIDTH-1:0] cap_data,

  output logic [ADDR_WIDTH-1:0] sram_addr,
  inout  wire  [DATA_WIDTH-1:0] sram_data,
  output logic                  sram_we_n,
  output logic                  sram_oe_n,
  output logic                  sram_ce_n
);

  logic                  drive_q;
  logic                  cap_en_q;
  logic [DATA_WIDTH-1:0] wdata_q;

  always_ff @(posedge axi_clk or negedge axi_resetn) begin
    if (!axi_resetn) begin
      sram_we_n <= 1'b1;
      sram_oe_n <= 1'b1;
      sram_ce_n <= 1'b1;
      drive_q   <= 1'b0;
      cap_en_q  <= 1'b0;
    end else begin
      sram_we_n <= !pin_we;
      sram_oe_n <= !pin_oe;
      sram_ce_n <= !pin_ce;
      drive_q   <= pin_drive;
      // delayed with the pins so the sample falls in the last oe_n low cycle
      cap_en_q  <= cap_en;
    end
  end

  always_ff @(posedge axi_clk) begin
    sram_addr <= pin_addr;
    wdata_q   <= pin_wdata;
    if (cap_en_q) begin
      cap_data <= sram_data;
    end
  end

  assign sram_data = drive_q ? wdata_q : {DATA_WIDTH{1'bz}};

endmodule

// ==== verilog/sram_pkg.sv ====
package sram_pkg;

  // axi response code, only okay is ever returned
  typedef logic [1:0] axi_resp_t;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // bus side transaction states
  typedef enum logic [2:0] {
    IDLE,
    WRITE_WAIT,
    WRITE_RESP,
    READ_WAIT,
    READ_RESP
  } slave_state_t;

  // chip cycle states
  // prefixed since both enums share this scope
  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_ACCESS,
    SEQ_DONE
  } seq_state_t;

endpackage
